// ==== Bender.yml ====
package:
  name: controller_port

sources:
  - hdl/pad_pkg.sv
  - hdl/pad_options.sv
  - hdl/mouse_tracker.sv
  - hdl/pad_mux.sv
  - hdl/pad_port_seq.sv
  - hdl/controller_top.sv
  - target: test
    files:
      - tests/pad_checker.sv
      - tests/tb_controller.sv

// ==== hdl/controller_top.sv ====
/* Controller port top level. Connects the option register, mouse
   tracker, pad multiplexer and port sequencer between host and console. */
`timescale 1ns/100ps
`default_nettype none

module controller_top
	import pad_pkg::*;
(
	input  logic                clk_sys,
	input  logic                reset,
	input  logic [31:0]         status,
	input  pad_state_t          pads [NUM_PADS],
	input  mouse_report_t       mouse,
	input  logic                mouse_strobe,
	input  pad_ctrl_t           ctrl,
	output logic [NIBBLE_W-1:0] pad_nibble
);

	pad_cfg_t              cfg;
	logic [7:0]            mouse_byte;
	logic [1:0]            pad0_buttons;
	logic [PAD_PORT_W-1:0] port;
	logic [PAD_DATA_W-1:0] pad_word;

	// ==============================
	// Options
	// ==============================
	pad_options u_options (
		.clk_sys (clk_sys),
		.reset   (reset),
		.status  (status),
		.cfg     (cfg)
	);

	// ==============================
	// Mouse on port 0
	// ==============================
	mouse_tracker u_mouse (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ctrl         (ctrl),
		.cfg          (cfg),
		.mouse        (mouse),
		.mouse_strobe (mouse_strobe),
		.pad0_buttons (pad0_buttons),
		.mouse_byte   (mouse_byte)
	);

	// ==============================
	// Pad words
	// ==============================
	pad_mux u_mux (
		.cfg          (cfg),
		.pads         (pads),
		.port         (port),
		.mouse_byte   (mouse_byte),
		.pad_word     (pad_word),
		.pad0_buttons (pad0_buttons)
	);

	// ==============================
	// Console side
	// ==============================
	pad_port_seq u_seq (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cfg        (cfg),
		.ctrl       (ctrl),
		.pad_word   (pad_word),
		.port       (port),
		.pad_nibble (pad_nibble)
	);

endmodule

`default_nettype wire

// ==== hdl/mouse_tracker.sv ====
/* Console mouse emulation on port 0. Accumulates host motion, publishes
   it at the start of each four-nibble read and resets the read on idle. */
`timescale 1ns/100ps
`default_nettype none

module mouse_tracker
	import pad_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,
	input  pad_ctrl_t     ctrl,
	input  pad_cfg_t      cfg,
	input  mouse_report_t mouse,
	input  logic          mouse_strobe,
	input  logic [1:0]    pad0_buttons,
	output logic [7:0]    mouse_byte
);

	logic                       clr_q;
	logic                       clr_rise;
	logic [MOUSE_TIMEOUT_W-1:0] idle_cnt;
	logic [1:0]                 nib_cnt;

	// Motion gathered since the last report
	logic [7:0] acc_x;
	logic [7:0] acc_y;

	// Motion being read out by the console
	logic [7:0] rep_x;
	logic [7:0] rep_y;

	assign clr_rise = ctrl.clr & ~clr_q;

	// ==============================
	// Idle timeout
	// ==============================
	// Counts while clr stays low, saturates at all ones
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idle_cnt <= '0;
			clr_q    <= 1'b0;
		end else begin
			clr_q <= ctrl.clr;
			if (ctrl.clr) begin
				idle_cnt <= '0;
			end else if (~&idle_cnt) begin
				idle_cnt <= idle_cnt + 1'b1;
			end
		end
	end

	// ==============================
	// Nibble sequence and reports
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nib_cnt <= 2'd3;
			rep_x   <= '0;
			rep_y   <= '0;
			acc_x   <= '0;
			acc_y   <= '0;
		end else begin
			if (&idle_cnt) begin
				nib_cnt <= 2'd3;
			end

			if (clr_rise) begin
				nib_cnt <= nib_cnt + 1'b1;
				// Wrap from 3 starts a new report
				if (&nib_cnt) begin
					rep_x <= acc_x;
					rep_y <= acc_y;
					acc_x <= '0;
					acc_y <= '0;
				end
			end

			// Console x runs opposite to the host
			if (mouse_strobe) begin
				acc_x <= 8'd0 - mouse.dx[7:0];
				acc_y <= mouse.dy[7:0];
			end

			if (!cfg.mouse_en) begin
				acc_x <= '0;
				acc_y <= '0;
			end
		end
	end

	// Upper nibble walks through the report, lower one has buttons
	always_comb begin
		case (nib_cnt)
			2'd0:    mouse_byte[7:4] = rep_x[7:4];
			2'd1:    mouse_byte[7:4] = rep_x[3:0];
			2'd2:    mouse_byte[7:4] = rep_y[7:4];
			default: mouse_byte[7:4] = rep_y[3:0];
		endcase
		mouse_byte[3:0] = ~{pad0_buttons, mouse.flags[0], mouse.flags[1]};
	end

endmodule

`default_nettype wire

// ==== hdl/pad_mux.sv ====
/* Joypad word builder. Converts each joystick into the console's
   active-low 16-bit pad word and picks the one for the current port. */
`timescale 1ns/100ps
`default_nettype none

module pad_mux
	import pad_pkg::*;
(
	input  pad_cfg_t                cfg,
	input  pad_state_t              pads [NUM_PADS],
	input  logic [PAD_PORT_W-1:0]   port,
	input  logic [7:0]              mouse_byte,
	output logic [PAD_DATA_W-1:0]   pad_word,
	output logic [1:0]              pad0_buttons
);

	// Pads after the optional swap of the first two
	pad_state_t            pad_eff   [NUM_PADS];
	logic [PAD_DATA_W-1:0] pad_words [NUM_PADS];

	// Active-low layout
	//   15..12 unused, 11..8 extra, 7..4 directions, 3..0 buttons
	function automatic logic [PAD_DATA_W-1:0] encode_pad(input pad_state_t p);
		return {4'h0, ~p.extra, ~p.up, ~p.right, ~p.left, ~p.down, ~p.buttons};
	endfunction

	// ==============================
	// Joystick swap
	// ==============================
	always_comb begin
		for (int i = 0; i < NUM_PADS; i++) begin
			pad_eff[i] = pads[i];
		end
		if (cfg.joy_swap) begin
			pad_eff[0] = pads[1];
			pad_eff[1] = pads[0];
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_PADS; i++) begin
			pad_words[i] = encode_pad(pad_eff[i]);
		end
	end

	// Select and run of port 0 are reported through the mouse byte
	assign pad0_buttons = pad_eff[0].buttons[1:0];

	// ==============================
	// Port select
	// ==============================
	always_comb begin
		if (port == '0 && cfg.mouse_en) begin
			// Mouse answers on both pages
			pad_word = {mouse_byte, mouse_byte};
		end else if (port < NUM_PADS) begin
			pad_word = pad_words[port];
		end else begin
			pad_word = PAD_IDLE_DATA;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pad_options.sv ====
/* Controller option register. Samples the host status word each cycle
   and hands the decoded options to the pad logic. */
`timescale 1ns/100ps
`default_nettype none

module pad_options
	import pad_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [31:0] status,
	output pad_cfg_t    cfg
);

	// ==============================
	// Option decode
	// ==============================
	pad_cfg_t cfg_next;

	always_comb begin
		cfg_next.joy_swap = status[STATUS_SWAP_BIT];
		cfg_next.turbotap = status[STATUS_TURBO_BIT];
		cfg_next.buttons6 = status[STATUS_SIX_BIT];
		cfg_next.mouse_en = status[STATUS_MOUSE_BIT];
	end

	// One cycle behind the status word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg <= '0;
		end else begin
			cfg <= cfg_next;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pad_pkg.sv ====
/* Shared types and constants for the joypad port logic.
   Modules pull these in with a wildcard import in their header. */
`default_nettype none

package pad_pkg;

	// ==============================
	// Sizes
	// ==============================
	localparam int NUM_PADS        = 5;
	localparam int PAD_PORT_W      = 3;
	localparam int PAD_DATA_W      = 16;
	localparam int NIBBLE_W        = 4;
	localparam int MOUSE_TIMEOUT_W = 15;

	// Unused multitap port reads as all buttons released
	localparam logic [PAD_DATA_W-1:0] PAD_IDLE_DATA = 16'h0FFF;

	// Controller option bits in the host status word
	localparam int STATUS_SWAP_BIT  = 8;
	localparam int STATUS_TURBO_BIT = 9;
	localparam int STATUS_SIX_BIT   = 10;
	localparam int STATUS_MOUSE_BIT = 11;

	// ==============================
	// Types
	// ==============================
	// One joystick, active high
	typedef struct packed {
		logic [3:0] extra;    // six-button page
		logic [3:0] buttons;  // I, II, select, run
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} pad_state_t;

	// Host mouse report, flags bit 0 left, bit 1 right
	typedef struct packed {
		logic [7:0] flags;
		logic [8:0] dy;
		logic [8:0] dx;
	} mouse_report_t;

	typedef struct packed {
		logic joy_swap;
		logic turbotap;
		logic buttons6;
		logic mouse_en;
	} pad_cfg_t;

	// Console joypad control lines
	typedef struct packed {
		logic clr;
		logic sel;
	} pad_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/pad_port_seq.sv ====
/* Joypad port sequencer. Follows the console's select and clear lines,
   steps the multitap port, flips the six-button page, latches the nibble. */
`timescale 1ns/100ps
`default_nettype none

module pad_port_seq
	import pad_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  pad_cfg_t              cfg,
	input  pad_ctrl_t             ctrl,
	input  logic [PAD_DATA_W-1:0] pad_word,
	output logic [PAD_PORT_W-1:0] port,
	output logic [NIBBLE_W-1:0]   pad_nibble
);

	pad_ctrl_t             ctrl_q;
	logic                  page;
	logic                  sel_rise;
	logic                  clr_rise;
	logic [NIBBLE_W-1:0]   nibble_next;

	assign sel_rise = ctrl.sel & ~ctrl_q.sel;
	assign clr_rise = ctrl.clr & ~ctrl_q.clr;

	// ==============================
	// Nibble select
	// ==============================
	// Page picks the low or high byte, sel picks the half
	always_comb begin
		case ({page, ctrl.sel})
			2'b00:   nibble_next = pad_word[3:0];
			2'b01:   nibble_next = pad_word[7:4];
			2'b10:   nibble_next = pad_word[11:8];
			default: nibble_next = pad_word[15:12];
		endcase
	end

	// ==============================
	// Port and page state
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl_q     <= '0;
			port       <= '0;
			page       <= 1'b0;
			pad_nibble <= '0;
		end else begin
			ctrl_q <= ctrl;

			if (ctrl.clr) begin
				// Clear holds the tap at port 0 and reads as zero
				port       <= '0;
				pad_nibble <= '0;
				if (clr_rise) begin
					page <= ~page & cfg.buttons6;
				end
			end else begin
				pad_nibble <= nibble_next;
				if (sel_rise && cfg.turbotap) begin
					port <= port + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/pad_pkg.sv
hdl/pad_options.sv
hdl/mouse_tracker.sv
hdl/pad_mux.sv
hdl/pad_port_seq.sv
hdl/controller_top.sv
tests/pad_checker.sv
tests/tb_controller.sv

// ==== tests/pad_checker.sv ====
/* Result checker for the controller port testbench. Compares pad_nibble
   on each check strobe, reports each test as it ends and the totals. */
`timescale 1ns/100ps
`default_nettype none

module pad_checker
	import pad_pkg::*;
(
	input  logic                clk_sys,
	input  logic [NIBBLE_W-1:0] pad_nibble,
	input  logic                chk_strobe,
	input  logic [7:0]          chk_test,
	input  logic [NIBBLE_W-1:0] chk_exp,
	input  logic                run_done,
	output int                  error_count,
	output int                  check_count
);

	int cur_test;
	int test_checks;
	int test_errors;
	int tests_run;
	int tests_failed;
	bit test_open;

	initial begin
		error_count  = 0;
		check_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_open    = 1'b0;
	end

	task close_test();
		if (test_open) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("Test %0d passed, %0d checks", cur_test, test_checks);
			end else begin
				tests_failed++;
				$display("Test %0d failed, %0d of %0d checks wrong",
					cur_test, test_errors, test_checks);
			end
			test_open = 1'b0;
		end
	endtask

	// Sampled before the DUT updates on this edge
	always @(posedge clk_sys) begin
		if (chk_strobe) begin
			if (test_open && chk_test != cur_test) begin
				close_test();
			end
			if (!test_open) begin
				cur_test    = chk_test;
				test_checks = 0;
				test_errors = 0;
				test_open   = 1'b1;
			end
			check_count++;
			test_checks++;
			if (pad_nibble !== chk_exp) begin
				error_count++;
				test_errors++;
				$display("[ERROR] %0d ns pad_nibble expected %h actual %h",
					$time, chk_exp, pad_nibble);
			end
		end
		if (run_done) begin
			close_test();
			$display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
				tests_run, tests_failed, check_count, error_count);
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_controller.sv ====
/* Testbench for the controller port. Applies a table of control, option and
   pad steps to controller_top and has pad_checker compare each read nibble. */
`timescale 1ns/100ps
`default_nettype none

module tb_controller
	import pad_pkg::*;
();

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 16;
	localparam int ROW_CYCLES   = 4;
	localparam int RAND_SEED    = 27478;
	localparam int NUM_PATS     = 2;

	localparam logic [31:0] ST_NONE  = 32'd0;
	localparam logic [31:0] ST_SWAP  = 32'd1 << STATUS_SWAP_BIT;
	localparam logic [31:0] ST_TURBO = 32'd1 << STATUS_TURBO_BIT;
	localparam logic [31:0] ST_SIX   = 32'd1 << STATUS_SIX_BIT;
	localparam logic [31:0] ST_MOUSE = 32'd1 << STATUS_MOUSE_BIT;

	// Expected nibble source
	localparam logic [1:0] EXP_CONST = 2'd0;
	localparam logic [1:0] EXP_BTN   = 2'd1;
	localparam logic [1:0] EXP_DIR   = 2'd2;
	localparam logic [1:0] EXP_EXT   = 2'd3;

	// Left button held, x = -0x35 = 0xCB, y = 0x47
	localparam mouse_report_t M_REP  = '{flags: 8'h01, dy: 9'h147, dx: 9'h035};
	localparam mouse_report_t M_NONE = '0;

	typedef struct packed {
		logic [7:0]    test;
		logic [31:0]   status;
		logic [1:0]    pat;
		pad_ctrl_t     ctrl;
		logic          strobe;
		mouse_report_t mouse;
		logic [1:0]    kind;
		logic [2:0]    pad;
		logic [3:0]    val;
	} step_t;

	logic                clk_sys;
	logic                reset;
	logic [31:0]         status;
	pad_state_t          pads [NUM_PADS];
	mouse_report_t       mouse;
	logic                mouse_strobe;
	pad_ctrl_t           ctrl;
	logic [NIBBLE_W-1:0] pad_nibble;

	logic                chk_strobe;
	logic [7:0]          chk_test;
	logic [NIBBLE_W-1:0] chk_exp;
	logic                run_done;
	int                  error_count;
	int                  check_count;

	pad_state_t  pat_set [NUM_PATS][NUM_PADS];
	step_t       steps [$];
	logic [31:0] rnd;
	logic        table_ready;
	longint      limit_ns;

	controller_top u_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.status       (status),
		.pads         (pads),
		.mouse        (mouse),
		.mouse_strobe (mouse_strobe),
		.ctrl         (ctrl),
		.pad_nibble   (pad_nibble)
	);

	pad_checker u_chk (
		.clk_sys     (clk_sys),
		.pad_nibble  (pad_nibble),
		.chk_strobe  (chk_strobe),
		.chk_test    (chk_test),
		.chk_exp     (chk_exp),
		.run_done    (run_done),
		.error_count (error_count),
		.check_count (check_count)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	task automatic add_row(input int test, input logic [31:0] st, input int pat,
			input logic clr, input logic sel, input logic strobe, input mouse_report_t m,
			input logic [1:0] kind, input int pad, input logic [3:0] val);
		step_t s;
		s.test     = test[7:0];
		s.status   = st;
		s.pat      = pat[1:0];
		s.ctrl.clr = clr;
		s.ctrl.sel = sel;
		s.strobe   = strobe;
		s.mouse    = m;
		s.kind     = kind;
		s.pad      = pad[2:0];
		s.val      = val;
		steps.push_back(s);
	endtask

	// Active-low nibble of the named joystick
	function automatic logic [3:0] expected_nibble(input step_t s);
		pad_state_t p;
		p = pat_set[s.pat][s.pad];
		case (s.kind)
			EXP_BTN: return ~p.buttons;
			EXP_DIR: return ~{p.up, p.right, p.left, p.down};
			EXP_EXT: return ~p.extra;
			default: return s.val;
		endcase
	endfunction

	task automatic build_table();
		// ==============================
		// Single pad, turbotap off
		// ==============================
		add_row(1, ST_NONE, 1, 0, 0, 0, M_NONE, EXP_BTN, 0, 4'h0);
		add_row(1, ST_NONE, 1, 0, 1, 0, M_NONE, EXP_DIR, 0, 4'h0);
		add_row(1, ST_NONE, 1, 1, 1, 0, M_NONE, EXP_CONST, 0, 4'h0);
		// ==============================
		// Multitap walk
		// ==============================
		add_row(2, ST_TURBO, 1, 1, 1, 0, M_NONE, EXP_CONST, 0, 4'h0);
		add_row(2, ST_TURBO, 1, 0, 0, 0, M_NONE, EXP_BTN, 0, 4'h0);
		for (int p = 1; p < NUM_PADS; p++) begin
			add_row(2, ST_TURBO, 1, 0, 1, 0, M_NONE, EXP_DIR, p, 4'h0);
			add_row(2, ST_TURBO, 1, 0, 0, 0, M_NONE, EXP_BTN, p, 4'h0);
		end
		// Port 5 is past the last pad
		add_row(2, ST_TURBO, 1, 0, 1, 0, M_NONE, EXP_CONST, 0, 4'hF);
		add_row(2, ST_TURBO, 1, 0, 0, 0, M_NONE, EXP_CONST, 0, 4'hF);
		add_row(2, ST_TURBO, 1, 1, 0, 0, M_NONE, EXP_CONST, 0, 4'h0);
		// ==============================
		// Six-button page
		// ==============================
		add_row(3, ST_SIX, 1, 1, 0, 0, M_NONE, EXP_CONST, 0, 4'h0);
		add_row(3, ST_SIX, 1, 0, 0, 0, M_NONE, EXP_BTN, 0, 4'h0);
		add_row(3, ST_SIX, 1, 1, 0, 0, M_NONE, EXP_CONST, 0, 4'h0);
		add_row(3, ST_SIX, 1, 0, 0, 0, M_NONE, EXP_EXT, 0, 4'h0);
		add_row(3, ST_SIX, 1, 0, 1, 0, M_NONE, EXP_CONST, 0, 4'h0);
		add_row(3, ST_SIX, 1, 1, 1, 0, M_NONE, EXP_CONST, 0, 4'h0);
		add_row(3, ST_SIX, 1, 0, 0, 0, M_NONE, EXP_BTN, 0, 4'h0);
		add_row(3, ST_SIX, 1, 1, 0, 0, M_NONE, EXP_CONST, 0, 4'h0);
		add_row(3, ST_SIX, 1, 0, 0, 0, M_NONE, EXP_EXT, 0, 4'h0);
		add_row(3, ST_SIX, 1, 1, 0, 0, M_NONE, EXP_CONST, 0, 4'h0);
		// ==============================
		// Joystick swap
		// ==============================
		add_row(4, ST_SWAP, 1, 1, 0, 0, M_NONE, EXP_CONST, 0, 4'h0);
		add_row(4, ST_SWAP, 1, 0, 0, 0, M_NONE, EXP_BTN, 1, 4'h0);
		add_row(4, ST_SWAP, 1, 0, 1, 0, M_NONE, EXP_DIR, 1, 4'h0);
		add_row(4, ST_SWAP, 1, 1, 1, 0, M_NONE, EXP_CONST, 0, 4'h0);
		// ==============================
		// Mouse, count is 2 on entry
		// ==============================
		add_row(5, ST_MOUSE, 0, 1, 1, 0, M_REP, EXP_CONST, 0, 4'h0);
		add_row(5, ST_MOUSE, 0, 0, 1, 0, M_REP, EXP_CONST, 0, 4'h0);
		add_row(5, ST_MOUSE, 0, 1, 1, 0, M_REP, EXP_CONST, 0, 4'h0);
		add_row(5, ST_MOUSE, 0, 1, 1, 1, M_REP, EXP_CONST, 0, 4'h0);
		// Not published until the wrap
		add_row(5, ST_MOUSE, 0, 0, 1, 0, M_REP, EXP_CONST, 0, 4'h0);
		add_row(5, ST_MOUSE, 0, 1, 1, 0, M_REP, EXP_CONST, 0, 4'h0);
		add_row(5, ST_MOUSE, 0, 0, 1, 0, M_REP, EXP_CONST, 0, 4'hC);
		add_row(5, ST_MOUSE, 0, 0, 0, 0, M_REP, EXP_CONST, 0, 4'hD);
		add_row(5, ST_MOUSE, 0, 1, 1, 0, M_REP, EXP_CONST, 0, 4'h0);
		add_row(5, ST_MOUSE, 0, 0, 1, 0, M_REP, EXP_CONST, 0, 4'hB);
		add_row(5, ST_MOUSE, 0, 1, 1, 0, M_REP, EXP_CONST, 0, 4'h0);
		add_row(5, ST_MOUSE, 0, 0, 1, 0, M_REP, EXP_CONST, 0, 4'h4);
		add_row(5, ST_MOUSE, 0, 1, 1, 0, M_REP, EXP_CONST, 0, 4'h0);
		add_row(5, ST_MOUSE, 0, 0, 1, 0, M_REP, EXP_CONST, 0, 4'h7);
		add_row(5, ST_MOUSE, 0, 0, 0, 0, M_REP, EXP_CONST, 0, 4'hD);
	endtask

	task automatic run_step(input step_t s);
		logic [3:0] exp;
		exp = expected_nibble(s);
		status       <= s.status;
		ctrl         <= s.ctrl;
		mouse        <= s.mouse;
		mouse_strobe <= s.strobe;
		for (int k = 0; k < NUM_PADS; k++) begin
			pads[k] <= pat_set[s.pat][k];
		end
		@(posedge clk_sys);
		mouse_strobe <= 1'b0;
		repeat (2) @(posedge clk_sys);
		chk_strobe <= 1'b1;
		chk_test   <= s.test;
		chk_exp    <= exp;
		@(posedge clk_sys);
		chk_strobe <= 1'b0;
	endtask

	initial begin
		clk_sys      = 1'b0;
		reset        = 1'b1;
		status       = '0;
		ctrl         = '0;
		mouse        = '0;
		mouse_strobe = 1'b0;
		chk_strobe   = 1'b0;
		chk_test     = '0;
		chk_exp      = '0;
		run_done     = 1'b0;
		table_ready  = 1'b0;
		rnd          = $urandom(RAND_SEED);
		// Pattern 0 all released, pattern 1 random buttons
		for (int k = 0; k < NUM_PADS; k++) begin
			pat_set[0][k] = '0;
			rnd = $urandom();
			pat_set[1][k] = rnd[11:0];
			pads[k] = pat_set[1][k];
		end
		build_table();
		table_ready = 1'b1;

		// Nibble must read 0 while reset is held
		repeat (RESET_CYCLES - 2) @(posedge clk_sys);
		chk_strobe <= 1'b1;
		chk_test   <= 8'd1;
		chk_exp    <= '0;
		@(posedge clk_sys);
		chk_strobe <= 1'b0;
		@(posedge clk_sys);
		reset <= 1'b0;

		foreach (steps[i]) begin
			run_step(steps[i]);
		end

		run_done <= 1'b1;
		@(posedge clk_sys);
		run_done <= 1'b0;
		@(posedge clk_sys);
		if (error_count == 0 && check_count == steps.size() + 1) begin
			$display("No errors");
		end else begin
			if (check_count != steps.size() + 1) begin
				$display("Only %0d of %0d checks ran", check_count, steps.size() + 1);
			end
			$display("Errors found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (table_ready);
		limit_ns = (2 * steps.size() * ROW_CYCLES + RESET_CYCLES) * CLK_PERIOD;
		#(limit_ns);
		$display("Watchdog timeout: run did not end within %0d ns", limit_ns);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
